//--- rtl/glue_pkg.sv
/*
 * system glue shared types
 * cpu bus request, peripheral strobe, address pages,
 * region decode and bus handshake states
 */
package glue_pkg;

	//--------------------------------------------------
	// cpu bus
	//--------------------------------------------------
	typedef logic [23:1] addr_t;   // word address
	typedef logic [15:0] data_t;

	typedef struct packed {
		addr_t       addr;
		logic        we;         // 1 = write
		logic [1:0]  bs;         // [1] upper byte, [0] lower byte
		data_t       wdata;
	} bus_req_t;

	// one access as seen by a single peripheral
	typedef struct packed {
		logic        sel;        // one cycle strobe
		logic        we;
		logic [1:0]  bs;
		logic [3:0]  rs;         // register select, addr[11:8]
		logic [7:0]  wdata;      // peripherals only take the low byte
		logic [3:0]  nib;        // rtc nibble index, addr[5:2]
	} target_req_t;

	//--------------------------------------------------
	// decode and control
	//--------------------------------------------------
	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_CIA,
		REGION_RTC
	} region_e;

	typedef enum logic [2:0] {
		BUS_IDLE,
		BUS_SELECT,   // strobe target
		BUS_WAIT,     // target registers its data
		BUS_ACK,      // capture read data, raise ack
		BUS_RELEASE   // hold until cpu drops req
	} bus_state_e;

	localparam logic [11:0] CIA_PAGE  = 12'hBFE;  // addr[23:12] of cia-a
	localparam logic [11:0] RTC_PAGE  = 12'hDC0;  // addr[23:12] of rtc
	localparam logic [7:0]  PRA_RESET = 8'h03;    // overlay and led set

endpackage

//--- rtl/reset_sequencer.sv
/*
 * reset sequencer
 * merges external and user reset requests and keeps
 * system reset asserted for a number of video frames
 */
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RESET_FRAMES = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic rst_ext,
	input  logic usrrst,
	input  logic sof,
	output logic sys_reset
);

	localparam int CNT_W = $clog2(RESET_FRAMES + 1);

	logic [CNT_W-1:0] frame_cnt;   // sof pulses seen since last request
	logic             rst_req;
	logic             last_frame;

	assign rst_req    = rst_ext | usrrst;
	assign last_frame = (frame_cnt == CNT_W'(RESET_FRAMES - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt <= '0;
			sys_reset <= 1'b1;
		end else if (rst_req) begin
			frame_cnt <= '0;       // restart hold-off
			sys_reset <= 1'b1;
		end else if (sys_reset && sof) begin
			frame_cnt <= frame_cnt + 1'b1;
			if (last_frame)
				sys_reset <= 1'b0;  // release on the last counted frame
		end
	end

endmodule

//--- rtl/bus_controller.sv
/*
 * cpu bus controller
 * four-phase req/ack handshake, address region decode,
 * one-cycle peripheral strobes and OR combining of the
 * returned read data
 */
`timescale 1ns/1ps

module bus_controller
	import glue_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        sys_reset,
	input  logic        req,
	input  bus_req_t    bus_req,
	input  data_t       cia_rdata,
	input  data_t       rtc_rdata,
	output logic        ack,
	output data_t       rdata,
	output target_req_t cia_req,
	output target_req_t rtc_req
);

	bus_state_e state;
	region_e    region;      // decode of the live request
	region_e    region_q;
	bus_req_t   req_q;       // latched access
	logic       cia_stb;
	logic       rtc_stb;
	logic       start;

	assign start = (state == BUS_IDLE) && req;

	//--------------------------------------------------
	// region decode, addr[23:12]
	//--------------------------------------------------
	always_comb begin
		if (bus_req.addr[23:12] == CIA_PAGE)
			region = REGION_CIA;
		else if (bus_req.addr[23:12] == RTC_PAGE)
			region = REGION_RTC;
		else
			region = REGION_NONE;  // acked, reads zero
	end

	// request payload, held for the whole access
	always_ff @(posedge clk) begin
		if (start)
			req_q <= bus_req;
	end

	//--------------------------------------------------
	// handshake fsm
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= BUS_IDLE;
			region_q <= REGION_NONE;
			cia_stb  <= 1'b0;
			rtc_stb  <= 1'b0;
			ack      <= 1'b0;
			rdata    <= '0;
		end else if (sys_reset) begin
			state    <= BUS_IDLE;
			region_q <= REGION_NONE;
			cia_stb  <= 1'b0;
			rtc_stb  <= 1'b0;
			ack      <= 1'b0;
			rdata    <= '0;
		end else begin
			cia_stb <= 1'b0;   // strobes last one cycle
			rtc_stb <= 1'b0;
			case (state)
				BUS_IDLE: begin
					if (req) begin
						region_q <= region;
						state    <= BUS_SELECT;
					end
				end
				BUS_SELECT: begin
					cia_stb <= (region_q == REGION_CIA);
					rtc_stb <= (region_q == REGION_RTC);
					state   <= BUS_WAIT;
				end
				BUS_WAIT:
					state <= BUS_ACK;      // target registers here
				BUS_ACK: begin
					rdata <= cia_rdata | rtc_rdata;  // idle targets return zero
					ack   <= 1'b1;
					state <= BUS_RELEASE;
				end
				BUS_RELEASE: begin
					if (!req) begin       // cpu done, drop ack
						ack   <= 1'b0;
						state <= BUS_IDLE;
					end
				end
				default:
					state <= BUS_IDLE;
			endcase
		end
	end

	//--------------------------------------------------
	// target strobes
	//--------------------------------------------------
	always_comb begin
		cia_req.sel   = cia_stb;
		cia_req.we    = req_q.we;
		cia_req.bs    = req_q.bs;
		cia_req.rs    = req_q.addr[11:8];
		cia_req.wdata = req_q.wdata[7:0];
		cia_req.nib   = req_q.addr[5:2];
		rtc_req       = cia_req;     // same payload, own select
		rtc_req.sel   = rtc_stb;
	end

endmodule

//--- rtl/cia_port.sv
/*
 * cia-a port registers
 * port a holds the kickstart overlay and power led bits,
 * port b is a plain read/write byte
 */
`timescale 1ns/1ps

module cia_port
	import glue_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        sys_reset,
	input  target_req_t cia_req,
	output data_t       cia_rdata,
	output logic        ovl,
	output logic        led
);

	logic [7:0] pra;       // port a output register
	logic [7:0] prb;       // port b output register
	logic [7:0] rd_mux;
	logic       wr_en;
	logic       rd_en;

	assign wr_en = cia_req.sel & cia_req.we & cia_req.bs[0];  // low byte lane only
	assign rd_en = cia_req.sel & ~cia_req.we;

	always_comb begin
		case (cia_req.rs)
			4'd0:    rd_mux = pra;
			4'd1:    rd_mux = prb;
			default: rd_mux = 8'h00;   // unimplemented registers
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pra       <= PRA_RESET;
			prb       <= 8'h00;
			cia_rdata <= '0;
		end else if (sys_reset) begin
			pra       <= PRA_RESET;
			prb       <= 8'h00;
			cia_rdata <= '0;
		end else begin
			if (wr_en && cia_req.rs == 4'd0)
				pra <= cia_req.wdata;
			if (wr_en && cia_req.rs == 4'd1)
				prb <= cia_req.wdata;
			cia_rdata <= rd_en ? {8'h00, rd_mux} : '0;  // zero keeps the OR bus clean
		end
	end

	assign ovl = pra[0];
	assign led = pra[1];

endmodule

//--- rtl/rtc_port.sv
/*
 * real-time clock reader
 * returns one nibble of the 64-bit clock value per read
 */
`timescale 1ns/1ps

module rtc_port
	import glue_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [63:0] rtc,
	input  target_req_t rtc_req,
	output data_t       rtc_rdata
);

	logic rd_en;

	assign rd_en = rtc_req.sel & ~rtc_req.we;   // writes have no effect

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rtc_rdata <= '0;
		else if (rd_en)
			rtc_rdata <= {12'h000, rtc[{rtc_req.nib, 2'b00} +: 4]};  // nibble 0 is lsb
		else
			rtc_rdata <= '0;
	end

endmodule

//--- rtl/led_dimmer.sv
/*
 * power led dimmer
 * free-running counter, led only lit for a short slice
 * of each period while the port a led bit is set
 */
`timescale 1ns/1ps

module led_dimmer #(
	parameter int LED_CNT_BITS = 6
) (
	input  logic clk,
	input  logic rst_n,
	input  logic led,
	output logic pwr_led
);

	logic [LED_CNT_BITS-1:0] led_cnt;
	logic                    dim;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cnt <= '0;
			dim     <= 1'b1;       // as if the count had just wrapped
		end else begin
			led_cnt <= led_cnt + 1'b1;
			dim     <= |led_cnt[LED_CNT_BITS-1 -: 4];  // upper four bits
		end
	end

	// led bit set: lit only while dim is low
	assign pwr_led = ~(led & dim);

endmodule

//--- rtl/glue_top.sv
/*
 * home computer system glue
 * reset sequencing, cpu bus control, cia-a port
 * registers, rtc nibble reads and power led dimming
 */
`timescale 1ns/1ps

module glue_top
	import glue_pkg::*;
#(
	parameter int RESET_FRAMES = 4,   // frames of boot hold-off
	parameter int LED_CNT_BITS = 6    // dimmer period 2**n cycles
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rst_ext,   // reset from control block
	input  logic        usrrst,    // user reset request
	input  logic        sof,       // start of frame pulse
	input  logic        req,
	input  bus_req_t    bus_req,
	input  logic [63:0] rtc,
	output logic        ack,
	output data_t       rdata,
	output logic        ovl,       // kickstart overlay
	output logic        pwr_led,
	output logic        rst_out
);

	logic        sys_reset;
	target_req_t cia_req;
	target_req_t rtc_req;
	data_t       cia_rdata;
	data_t       rtc_rdata;
	logic        led;        // port a led bit

	assign rst_out = sys_reset;  // reset status to the outside

	reset_sequencer #(
		.RESET_FRAMES(RESET_FRAMES)
	) u_reset_sequencer (
		.clk      (clk),
		.rst_n    (rst_n),
		.rst_ext  (rst_ext),
		.usrrst   (usrrst),
		.sof      (sof),
		.sys_reset(sys_reset)
	);

	bus_controller u_bus_controller (
		.clk      (clk),
		.rst_n    (rst_n),
		.sys_reset(sys_reset),
		.req      (req),
		.bus_req  (bus_req),
		.cia_rdata(cia_rdata),
		.rtc_rdata(rtc_rdata),
		.ack      (ack),
		.rdata    (rdata),
		.cia_req  (cia_req),
		.rtc_req  (rtc_req)
	);

	// both peripherals sit side by side on the strobe bus
	cia_port u_cia_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.sys_reset(sys_reset),
		.cia_req  (cia_req),
		.cia_rdata(cia_rdata),
		.ovl      (ovl),
		.led      (led)
	);

	rtc_port u_rtc_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.rtc      (rtc),
		.rtc_req  (rtc_req),
		.rtc_rdata(rtc_rdata)
	);

	led_dimmer #(
		.LED_CNT_BITS(LED_CNT_BITS)
	) u_led_dimmer (
		.clk    (clk),
		.rst_n  (rst_n),
		.led    (led),
		.pwr_led(pwr_led)
	);

endmodule

//--- verification/tb_glue.sv
/*
 * testbench for the system glue top level
 * runs bus operations from a vector file through the
 * four-phase handshake and checks reset hold-off, cia-a
 * port registers, rtc nibble reads and led dimming
 */
`timescale 1ns/1ps

module tb_glue
	import glue_pkg::*;
();

	localparam int    RESET_FRAMES = 4;      // dut default
	localparam int    SOF_PERIOD   = 20;     // cycles between frame pulses
	localparam int    LED_PERIOD   = 64;     // 2**LED_CNT_BITS
	localparam int    NUM_RAND     = 8;      // random prb round trips
	localparam string VEC_FILE     = "verification/bus_input.txt";
	localparam logic [23:0] PRB_ADDR = 24'hBFE101;

	logic        clk;
	logic        rst_n;
	logic        rst_ext;
	logic        usrrst;
	logic        sof;
	logic        req;
	bus_req_t    bus_req;
	logic [63:0] rtc;
	logic        ack;
	data_t       rdata;
	logic        ovl;
	logic        pwr_led;
	logic        rst_out;

	// vectors, one entry per file line
	string       cmd_q[$];
	logic [23:0] addr_q[$];
	logic [1:0]  bs_q[$];
	logic [15:0] wdata_q[$];
	logic [15:0] exp_q[$];

	int          cycle_cnt;
	int          cycle_limit;    // zero until the vectors are known
	integer      seed;

	glue_top UUT (
		.clk    (clk),
		.rst_n  (rst_n),
		.rst_ext(rst_ext),
		.usrrst (usrrst),
		.sof    (sof),
		.req    (req),
		.bus_req(bus_req),
		.rtc    (rtc),
		.ack    (ack),
		.rdata  (rdata),
		.ovl    (ovl),
		.pwr_led(pwr_led),
		.rst_out(rst_out)
	);

	always #5 clk = ~clk;   // 10 ns period

	//--------------------------------------------------
	// frame pulses and run limit
	//--------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: bus handshake or reset release stuck after %0d cycles",
				cycle_cnt);
			$display("Simulation finished: FAIL");
			$fatal(1, "run limit reached");
		end
	end

	always @(posedge clk) begin
		#1;
		sof = (cycle_cnt % SOF_PERIOD == 0);  // one cycle wide
	end

	//--------------------------------------------------
	// helpers
	//--------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic load_vectors();
		integer      fd;
		string       line;
		string       cmd;
		logic [23:0] addr;
		logic [1:0]  bs;
		logic [15:0] wdata;
		logic [15:0] expected;
		int          n;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("could not open the vector file %s", VEC_FILE);
			$display("Simulation finished: FAIL");
			$fatal(1, "no vector file");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments
				n = $sscanf(line, "%s %h %h %h %h", cmd, addr, bs, wdata, expected);
				if (n == 5) begin
					cmd_q.push_back(cmd);
					addr_q.push_back(addr);
					bs_q.push_back(bs);
					wdata_q.push_back(wdata);
					exp_q.push_back(expected);
				end
			end
		end
		$fclose(fd);
	endtask

	// one four-phase access, addr is a byte address
	task automatic bus_access(input logic we, input logic [23:0] addr,
			input logic [1:0] bs, input logic [15:0] wdata, output logic [15:0] data);
		@(posedge clk);
		#1;
		bus_req.addr  = addr[23:1];
		bus_req.we    = we;
		bus_req.bs    = bs;
		bus_req.wdata = wdata;
		req           = 1'b1;
		do
			@(negedge clk);
		while (!ack);
		data = rdata;        // stable while ack is high
		@(posedge clk);
		#1;
		req = 1'b0;
		do
			@(negedge clk);
		while (ack);
	endtask

	// counts the sof pulses taken while rst_out is held
	task automatic wait_reset_release(input string name, output int frames);
		frames = 0;
		do begin
			@(negedge clk);
			check_value({name, " ack low"}, 0, ack);
			if (rst_out && sof)
				frames++;
		end while (rst_out);
	endtask

	task automatic led_window(input string name, input int exp_lit, input logic exp_ovl);
		int lit;
		lit = 0;
		check_value({name, " ovl"}, exp_ovl, ovl);
		repeat (LED_PERIOD) begin
			@(negedge clk);
			if (pwr_led)
				lit++;
		end
		check_value({name, " lit cycles"}, exp_lit, lit);
	endtask

	task automatic ext_reset(input string name, input int exp_frames);
		int frames;
		@(posedge clk);
		#1;
		rst_ext = 1'b1;
		@(posedge clk);
		#1;
		rst_ext = 1'b0;
		wait_reset_release(name, frames);
		check_value({name, " frames"}, exp_frames, frames);
		check_value({name, " ovl"}, 1, ovl);   // pra back at reset value
	endtask

	task automatic run_vector(input int i);
		string       name;
		logic [15:0] data;
		name = $sformatf("vec %0d %s %06h", i, cmd_q[i], addr_q[i]);
		if (cmd_q[i] == "W") begin
			bus_access(1'b1, addr_q[i], bs_q[i], wdata_q[i], data);
			check_value(name, exp_q[i], data);   // writes return zero
		end else if (cmd_q[i] == "R") begin
			bus_access(1'b0, addr_q[i], bs_q[i], wdata_q[i], data);
			check_value(name, exp_q[i], data);
		end else if (cmd_q[i] == "X") begin
			ext_reset(name, exp_q[i]);
		end else if (cmd_q[i] == "L") begin
			led_window(name, exp_q[i], wdata_q[i][0]);  // wdata column is ovl
		end else begin
			$display("unknown command %s in vector %0d", cmd_q[i], i);
			$display("Simulation finished: FAIL");
			$fatal(1, "bad vector");
		end
	endtask

	//--------------------------------------------------
	// main sequence
	//--------------------------------------------------
	initial begin : main_seq
		int          frames;
		logic [31:0] rnd;
		logic [15:0] data;
		clk         = 1'b0;
		rst_n       = 1'b0;
		rst_ext     = 1'b0;
		usrrst      = 1'b0;
		sof         = 1'b0;
		req         = 1'b0;
		bus_req     = '0;
		rtc         = 64'h0123_4567_89AB_CDEF;
		cycle_cnt   = 0;
		cycle_limit = 0;
		seed        = 66872;

		load_vectors();
		if (cmd_q.size() == 0) begin
			$display("the vector file holds no operations");
			$display("Simulation finished: FAIL");
			$fatal(1, "empty vector file");
		end
		cycle_limit = (cmd_q.size() + NUM_RAND) * 40 + RESET_FRAMES * 20 + 200;

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		wait_reset_release("power-on reset", frames);
		check_value("power-on reset frames", RESET_FRAMES, frames);
		check_value("power-on reset ovl", 1, ovl);

		foreach (cmd_q[i])
			run_vector(i);

		// prb round trips with random data
		for (int k = 0; k < NUM_RAND; k++) begin
			rnd = $random(seed);
			bus_access(1'b1, PRB_ADDR, 2'b11, rnd[15:0], data);
			bus_access(1'b0, PRB_ADDR, 2'b11, 16'h0000, data);
			check_value($sformatf("random prb %0d", k), {8'h00, rnd[7:0]}, data);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- vlog.f
rtl/glue_pkg.sv
rtl/reset_sequencer.sv
rtl/bus_controller.sv
rtl/cia_port.sv
rtl/rtc_port.sv
rtl/led_dimmer.sv
rtl/glue_top.sv
verification/tb_glue.sv

//--- verification/bus_input.txt
# cmd byte_addr bs wdata expected (hex) W write R read X ext reset L led window
# X expected = sof pulses held, L expected = lit cycles of 64 and wdata = ovl level
R BFE001 1 0000 0003
R BFE101 1 0000 0000
W BFE101 3 12A5 0000
R BFE101 3 0000 00A5
W BFE101 2 005A 0000
R BFE101 1 0000 00A5
L 000000 0 0001 0004
W BFE001 1 0002 0000
R BFE001 1 0000 0002
L 000000 0 0000 0004
W BFE001 1 0000 0000
L 000000 0 0000 0040
W BFE201 1 00FF 0000
R BFE201 1 0000 0000
R DC0000 3 0000 000F
R DC0004 3 0000 000E
R DC0020 3 0000 0007
R DC003C 3 0000 0000
W DC0004 3 FFFF 0000
R DC0004 3 0000 000E
R 123456 3 0000 0000
W 123456 3 BEEF 0000
X 000000 0 0000 0004
R BFE001 1 0000 0003
R BFE101 1 0000 0000
L 000000 0 0001 0004
